/* board_regs/board_regs.sv */
// board control registers
// channel 0 writable state: axis enables, relay, motor power, digital
// outputs, phy scratch words and watchdog period. watchdog and safety
// disables latch into the enable state between writes.

`timescale 1ns/1ps

module board_regs (
    input  logic                  sysclk,
    input  logic                  reset,
    reg_bus_if.receiver           bus,
    board_state_if.driver         state,
    input  board_pkg::axis_mask_t wdog_amp_disable,
    input  board_pkg::axis_mask_t mv_amp_disable,
    input  board_pkg::axis_mask_t safety_amp_disable,
    output board_pkg::axis_mask_t amp_disable
);
    import board_pkg::*;

    axis_mask_t en_mask;    // status wdata[11:8]
    axis_mask_t en_value;   // status wdata[3:0], 1 -> enable
    axis_mask_t dis_next;   // disable after a status write
    axis_mask_t dout_next;

    // ----------------------------------------------------------------------
    // masked write values
    assign en_mask  = bus.wdata[11:8];
    assign en_value = bus.wdata[3:0];

    // masked axes take ~value, others hold; power off forces disable
    assign dis_next = {4{~state.pwr_enable}}
                    | (en_mask & ~en_value)
                    | (~en_mask & state.reg_disable);

    assign dout_next = (bus.wdata[11:8] & bus.wdata[3:0])
                     | (~bus.wdata[11:8] & state.dout);

    // ----------------------------------------------------------------------
    // register file
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state.reg_disable <= '1;                  // all axes off
            state.pwr_enable  <= 1'b0;
            state.relay_on    <= 1'b0;
            state.dout        <= '0;
            state.phy_ctrl    <= '0;
            state.phy_data    <= '0;
            state.wdog_period <= WDOG_PERIOD_RESET;
        end else if (bus.wr_en) begin
            case (bus.reg_index)
                REG_STATUS: begin
                    state.reg_disable <= dis_next;
                    if (bus.wdata[17])
                        state.relay_on <= bus.wdata[16];
                    if (bus.wdata[19])
                        state.pwr_enable <= bus.wdata[18];
                end
                REG_PHYCTRL: state.phy_ctrl    <= bus.wdata[15:0];
                REG_PHYDATA: state.phy_data    <= bus.wdata[15:0];
                REG_TIMEOUT: state.wdog_period <= bus.wdata[15:0];
                REG_DIGIOUT: state.dout        <= dout_next;
                default: ;                        // read-only or external
            endcase
        end else begin
            // latch external disables until the host re-enables
            state.reg_disable <= state.reg_disable
                               | wdog_amp_disable
                               | safety_amp_disable;
        end
    end

    // settle timer holds axes off without touching the register
    assign amp_disable = state.reg_disable | mv_amp_disable;

    // a watchdog trip between writes must latch every axis off
    a_wdog_latch: assert property (
        @(posedge sysclk) disable iff (!reset)
        (!bus.wr_en && (wdog_amp_disable == '1)) |=> (state.reg_disable == '1)
    );

endmodule

/* board_regs/safety_monitor.sv */
// safety monitor
// tick prescaler, host watchdog and motor-voltage settle timer. state
// moves on tick cycles only; a host write clears the watchdog at once.

`timescale 1ns/1ps

module safety_monitor #(
    parameter int                TICK_WIDTH   = board_pkg::WDOG_TICK_WIDTH,
    parameter board_pkg::period_t SETTLE_TICKS = board_pkg::MV_SETTLE_TICKS
) (
    input  logic                   sysclk,
    input  logic                   reset,
    reg_bus_if.receiver            bus,
    board_state_if.receiver        state,
    input  logic                   mv_good,
    output logic                   wdog_timeout,
    output board_pkg::axis_mask_t  wdog_amp_disable,
    output board_pkg::axis_mask_t  mv_amp_disable
);
    import board_pkg::*;

    logic [TICK_WIDTH-1:0] prescale;
    logic                  tick;           // one cycle per 2^TICK_WIDTH
    period_t               wdog_count;     // ticks since last host write
    period_t               settle_count;   // ticks with mv_good high

    assign tick = &prescale;

    // ----------------------------------------------------------------------
    // free running prescaler
    always_ff @(posedge sysclk) begin
        if (!reset)
            prescale <= '0;
        else
            prescale <= prescale + 1'b1;
    end

    // ----------------------------------------------------------------------
    // watchdog, period 0 turns it off
    always_ff @(posedge sysclk) begin
        if (!reset || bus.kick) begin
            wdog_count       <= '0;
            wdog_timeout     <= 1'b0;
            wdog_amp_disable <= '0;
        end else if (tick && (state.wdog_period != '0)) begin
            if (wdog_count < state.wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                wdog_timeout     <= 1'b1;          // host went quiet
                wdog_amp_disable <= '1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // motor voltage settle
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            settle_count   <= '0;
            mv_amp_disable <= '1;
        end else if (tick) begin
            if (!mv_good) begin
                settle_count   <= '0;              // restart on supply loss
                mv_amp_disable <= '1;
            end else if (settle_count < SETTLE_TICKS) begin
                settle_count   <= settle_count + 1'b1;
                mv_amp_disable <= '1;
            end else begin
                mv_amp_disable <= '0;              // supply settled
            end
        end
    end

    // period is written together with a kick, so the count can't overshoot
    a_wdog_bound: assert property (
        @(posedge sysclk) disable iff (!reset)
        (state.wdog_period != '0) |-> (wdog_count <= state.wdog_period)
    );

endmodule

/* common/board_pkg.sv */
// board register package
// channel 0 register map, board constants and shared widths for the
// four-axis amplifier controller register block

package board_pkg;

    // ----------------------------------------------------------------------
    // widths
    typedef logic [3:0]  reg_index_t;   // register index within channel 0
    typedef logic [7:0]  host_addr_t;   // channel nibble + register index
    typedef logic [31:0] reg_word_t;    // register data word
    typedef logic [3:0]  axis_mask_t;   // bit 0 is axis 1
    typedef logic [15:0] period_t;      // watchdog period in ticks

    // ----------------------------------------------------------------------
    // channel 0 register map
    localparam reg_index_t REG_STATUS     = 4'd0;   // id, fault, enables
    localparam reg_index_t REG_PHYCTRL    = 4'd1;   // phy request scratch
    localparam reg_index_t REG_PHYDATA    = 4'd2;   // phy data scratch
    localparam reg_index_t REG_TIMEOUT    = 4'd3;   // watchdog period
    localparam reg_index_t REG_VERSION    = 4'd4;
    localparam reg_index_t REG_TEMPSNS    = 4'd5;   // 2x 8 bit sensors
    localparam reg_index_t REG_DIGIOUT    = 4'd6;
    localparam reg_index_t REG_FW_VERSION = 4'd7;
    localparam reg_index_t REG_PROMSTAT   = 4'd8;
    localparam reg_index_t REG_PROMRES    = 4'd9;
    localparam reg_index_t REG_DIGIN      = 4'd10;  // home, limits, v_fault
    localparam reg_index_t REG_SAFETY     = 4'd11;
    localparam reg_index_t REG_WDOG       = 4'd14;  // watchdog disable mask
    localparam reg_index_t REG_REGDISABLE = 4'd15;  // combined disable

    // ----------------------------------------------------------------------
    // constants
    localparam reg_word_t BOARD_VERSION = 32'h514C4131;  // "QLA1"
    localparam reg_word_t FW_VERSION    = 32'h0000_0003;
    localparam logic [3:0] NUM_AXES     = 4'd4;

    // one tick is 2^8 sysclk cycles
    localparam int WDOG_TICK_WIDTH = 8;

    // settle window after mv_good, in ticks
    localparam period_t MV_SETTLE_TICKS   = 16'd7680;
    localparam period_t WDOG_PERIOD_RESET = 16'hFFFF;

endpackage

/* common/board_state_if.sv */
// live board control state
// register file contents shared with readback and the safety logic

`timescale 1ns/1ps

interface board_state_if;
    import board_pkg::*;

    axis_mask_t  reg_disable;   // 1 -> axis disabled
    logic        pwr_enable;    // motor power
    logic        relay_on;      // safety relay drive
    axis_mask_t  dout;          // digital outputs
    logic [15:0] phy_ctrl;
    logic [15:0] phy_data;
    period_t     wdog_period;   // 0 disables the watchdog

    modport driver (
        output reg_disable, pwr_enable, relay_on, dout,
        output phy_ctrl, phy_data, wdog_period
    );

    modport receiver (
        input reg_disable, pwr_enable, relay_on, dout,
        input phy_ctrl, phy_data, wdog_period
    );

endinterface

/* common/reg_bus_if.sv */
// decoded host access bus
// carries registered channel 0 accesses and the watchdog kick from the
// host side to the register, readback and safety blocks

`timescale 1ns/1ps

interface reg_bus_if;
    import board_pkg::*;

    reg_index_t reg_index;  // register index, level
    reg_word_t  wdata;      // write data
    logic       wr_en;      // channel 0 write this cycle
    logic       kick;       // any host write, any channel

    modport driver (
        output reg_index,
        output wdata,
        output wr_en,
        output kick
    );

    modport receiver (
        input reg_index,
        input wdata,
        input wr_en,
        input kick
    );

endinterface

/* logic/board_ctrl_top.sv */
// board controller top
// channel 0 board register block of the four-axis amplifier controller:
// host port, control registers, safety monitor and readback

`timescale 1ns/1ps

module board_ctrl_top #(
    parameter int                 TICK_WIDTH   = board_pkg::WDOG_TICK_WIDTH,
    parameter board_pkg::period_t SETTLE_TICKS = board_pkg::MV_SETTLE_TICKS
) (
    input  logic                  sysclk,
    input  logic                  reset,
    // host register bus
    input  board_pkg::host_addr_t reg_addr,
    input  board_pkg::reg_word_t  reg_wdata,
    input  logic                  reg_wen,
    output board_pkg::reg_word_t  reg_rdata,
    // board inputs
    input  logic [3:0]            board_id,
    input  board_pkg::axis_mask_t fault,
    input  board_pkg::axis_mask_t neg_limit,
    input  board_pkg::axis_mask_t pos_limit,
    input  board_pkg::axis_mask_t home,
    input  logic                  relay,
    input  logic                  mv_good,
    input  logic                  v_fault,
    input  logic [15:0]           temp_sense,
    input  board_pkg::reg_word_t  prom_status,
    input  board_pkg::reg_word_t  prom_result,
    input  board_pkg::axis_mask_t safety_amp_disable,
    // board outputs
    output board_pkg::axis_mask_t amp_disable,
    output board_pkg::axis_mask_t dout,
    output logic                  pwr_enable,
    output logic                  relay_on
);
    import board_pkg::*;

    logic       wdog_timeout;
    axis_mask_t wdog_amp_disable;
    axis_mask_t mv_amp_disable;

    reg_bus_if     bus ();
    board_state_if state ();

    host_port u_host_port (
        .sysclk, .reset, .reg_addr, .reg_wdata, .reg_wen, .bus(bus.driver)
    );

    board_regs u_board_regs (
        .sysclk, .reset, .bus(bus.receiver), .state(state.driver),
        .wdog_amp_disable, .mv_amp_disable, .safety_amp_disable, .amp_disable
    );

    safety_monitor #(.TICK_WIDTH(TICK_WIDTH), .SETTLE_TICKS(SETTLE_TICKS)) u_safety (
        .sysclk, .reset, .bus(bus.receiver), .state(state.receiver),
        .mv_good, .wdog_timeout, .wdog_amp_disable, .mv_amp_disable
    );

    readback_mux u_readback (
        .sysclk, .reset, .bus(bus.receiver), .state(state.receiver),
        .wdog_timeout, .wdog_amp_disable, .amp_disable, .board_id, .fault,
        .neg_limit, .pos_limit, .home, .relay, .mv_good, .v_fault, .temp_sense,
        .prom_status, .prom_result, .safety_amp_disable, .reg_rdata
    );

    // board drive pins straight from the register file
    assign dout       = state.dout;
    assign pwr_enable = state.pwr_enable;
    assign relay_on   = state.relay_on;

endmodule

/* logic/host_port.sv */
// host port
// registers the host register bus, decodes channel 0 writes and raises
// the watchdog kick on every write

`timescale 1ns/1ps

module host_port (
    input  logic                  sysclk,
    input  logic                  reset,      // sync, active low
    input  board_pkg::host_addr_t reg_addr,
    input  board_pkg::reg_word_t  reg_wdata,
    input  logic                  reg_wen,
    reg_bus_if.driver             bus
);
    import board_pkg::*;

    logic [3:0] channel;    // upper address nibble

    assign channel = reg_addr[7:4];

    // payload, no reset needed
    always_ff @(posedge sysclk) begin
        bus.reg_index <= reg_addr[3:0];
        bus.wdata     <= reg_wdata;
    end

    // strobes
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            bus.wr_en <= 1'b0;
            bus.kick  <= 1'b0;
        end else begin
            bus.wr_en <= reg_wen && (channel == 4'd0);  // board channel only
            bus.kick  <= reg_wen;                       // any channel feeds watchdog
        end
    end

endmodule

/* logic/readback_mux.sv */
// register readback
// continuous read path, one register stage from index to read data

`timescale 1ns/1ps

module readback_mux (
    input  logic                   sysclk,
    input  logic                   reset,
    reg_bus_if.receiver            bus,
    board_state_if.receiver        state,
    input  logic                   wdog_timeout,
    input  board_pkg::axis_mask_t  wdog_amp_disable,
    input  board_pkg::axis_mask_t  amp_disable,
    input  logic [3:0]             board_id,      // rotary switch
    input  board_pkg::axis_mask_t  fault,
    input  board_pkg::axis_mask_t  neg_limit,
    input  board_pkg::axis_mask_t  pos_limit,
    input  board_pkg::axis_mask_t  home,
    input  logic                   relay,
    input  logic                   mv_good,
    input  logic                   v_fault,
    input  logic [15:0]            temp_sense,
    input  board_pkg::reg_word_t   prom_status,
    input  board_pkg::reg_word_t   prom_result,
    input  board_pkg::axis_mask_t  safety_amp_disable,
    output board_pkg::reg_word_t   reg_rdata
);
    import board_pkg::*;

    reg_word_t status_word;
    reg_word_t rd_next;

    assign status_word = {
        NUM_AXES, board_id,                       // byte 3
        wdog_timeout, 3'd0,                       // byte 2
        mv_good, state.pwr_enable, ~relay, state.relay_on,
        4'd0, fault,                              // byte 1
        4'd0, ~state.reg_disable                  // byte 0, 1 -> enabled
    };

    always_comb begin
        case (bus.reg_index)
            REG_STATUS:     rd_next = status_word;
            REG_PHYCTRL:    rd_next = {16'd0, state.phy_ctrl};
            REG_PHYDATA:    rd_next = {16'd0, state.phy_data};
            REG_TIMEOUT:    rd_next = {16'd0, state.wdog_period};
            REG_VERSION:    rd_next = BOARD_VERSION;
            REG_TEMPSNS:    rd_next = {16'd0, temp_sense};
            REG_DIGIOUT:    rd_next = {28'd0, state.dout};
            REG_FW_VERSION: rd_next = FW_VERSION;
            REG_PROMSTAT:   rd_next = prom_status;
            REG_PROMRES:    rd_next = prom_result;
            REG_DIGIN:      rd_next = {15'd0, v_fault, state.dout, neg_limit, pos_limit, home};
            REG_SAFETY:     rd_next = {28'd0, safety_amp_disable};
            REG_WDOG:       rd_next = {28'd0, wdog_amp_disable};
            REG_REGDISABLE: rd_next = {28'd0, amp_disable};
            default:        rd_next = '0;         // unmapped
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!reset)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_next;
    end

    // host never sees stale data out of reset
    a_rdata_reset: assert property (
        @(posedge sysclk) !reset |=> (reg_rdata == '0)
    );

endmodule

/* tb.f */
common/board_pkg.sv
common/reg_bus_if.sv
common/board_state_if.sv
logic/host_port.sv
board_regs/board_regs.sv
board_regs/safety_monitor.sv
logic/readback_mux.sv
logic/board_ctrl_top.sv
verif/board_ctrl_tb.sv

/* verif/board_ctrl_tb.sv */
// board controller testbench
// drives the channel 0 host bus and board pins of board_ctrl_top with a
// short tick and settle window, checks read data and board outputs
// through concurrent assertions and reports per test

`timescale 1ns/1ps

module board_ctrl_tb;
    import board_pkg::*;

    localparam int          TB_TICK_WIDTH = 2;        // 4 cycles per tick
    localparam period_t     TB_SETTLE     = 16'd5;
    localparam logic [15:0] LFSR_SEED     = 16'd59545;
    localparam logic [15:0] LFSR_TAPS     = 16'hB400; // x^16+x^14+x^13+x^11+1
    localparam int          WAIT_LIMIT    = 200;      // cycles
    localparam int          POLL_LIMIT    = 40;       // status reads

    logic        sysclk;
    logic        reset;
    host_addr_t  reg_addr;
    reg_word_t   reg_wdata;
    logic        reg_wen;
    reg_word_t   reg_rdata;
    logic [3:0]  board_id;
    axis_mask_t  fault, neg_limit, pos_limit, home, safety_amp_disable;
    logic        relay, mv_good, v_fault;
    logic [15:0] temp_sense;
    reg_word_t   prom_status, prom_result;
    axis_mask_t  amp_disable, dout;
    logic        pwr_enable, relay_on;

    logic [15:0] lfsr;
    int          errors, checks, test_num, errors_at_start;
    logic        rd_check, out_check;      // one-cycle check strobes
    reg_word_t   rd_exp, rd_mask;
    axis_mask_t  exp_amp, exp_dout, dout_model;
    logic        exp_pwr, exp_relay;

    board_ctrl_top #(.TICK_WIDTH(TB_TICK_WIDTH), .SETTLE_TICKS(TB_SETTLE)) dut (.*);

    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;           // 100 ns period

    // ----------------------------------------------------------------------
    // checks
    a_rdata: assert property (@(posedge sysclk) rd_check |-> ((reg_rdata & rd_mask) == rd_exp))
        else begin
            errors++;
            $display("ERR reg_rdata got %h exp %h mask %h",
                     $sampled(reg_rdata), $sampled(rd_exp), $sampled(rd_mask));
        end
    a_amp: assert property (@(posedge sysclk) out_check |-> (amp_disable == exp_amp))
        else begin
            errors++;
            $display("ERR amp_disable got %h exp %h", $sampled(amp_disable), $sampled(exp_amp));
        end
    a_pwr: assert property (@(posedge sysclk) out_check |-> (pwr_enable == exp_pwr))
        else begin
            errors++;
            $display("ERR pwr_enable got %h exp %h", $sampled(pwr_enable), $sampled(exp_pwr));
        end
    a_relay: assert property (@(posedge sysclk) out_check |-> (relay_on == exp_relay))
        else begin
            errors++;
            $display("ERR relay_on got %h exp %h", $sampled(relay_on), $sampled(exp_relay));
        end
    a_dout: assert property (@(posedge sysclk) out_check |-> (dout == exp_dout))
        else begin
            errors++;
            $display("ERR dout got %h exp %h", $sampled(dout), $sampled(exp_dout));
        end

    // ----------------------------------------------------------------------
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        b;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (b ? LFSR_TAPS : 16'h0);
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    // all tasks start and end just after a rising edge
    task automatic write_reg(input host_addr_t addr, input reg_word_t data);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);                 // host port samples
        reg_wen   <= 1'b0;
        @(posedge sysclk);                 // register state moves
    endtask

    task automatic read_check(input reg_index_t idx, input reg_word_t mask, input reg_word_t exp);
        reg_addr <= {4'd0, idx};
        repeat (2) @(posedge sysclk);      // fixed two-edge read latency
        rd_exp   <= exp;
        rd_mask  <= mask;
        rd_check <= 1'b1;
        checks++;
        @(posedge sysclk);
        rd_check <= 1'b0;
    endtask

    task automatic read_word(input reg_index_t idx, output reg_word_t data);
        reg_addr <= {4'd0, idx};
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        data = reg_rdata;
        @(posedge sysclk);
    endtask

    task automatic check_outputs(input axis_mask_t amp, input logic pwr, input logic rel,
                                 input axis_mask_t dv);
        exp_amp   <= amp;
        exp_pwr   <= pwr;
        exp_relay <= rel;
        exp_dout  <= dv;
        out_check <= 1'b1;
        checks++;
        @(posedge sysclk);
        out_check <= 1'b0;
    endtask

    task automatic wait_amp(input axis_mask_t exp);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < WAIT_LIMIT) begin
            @(negedge sysclk);
            hit = (amp_disable == exp);
            n++;
        end
        @(posedge sysclk);
        if (!hit) begin
            errors++;
            $display("timeout: amp_disable never reached %h", exp);
        end
    endtask

    task automatic wait_wdog_trip();
        int        n;
        bit        hit;
        reg_word_t word;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < POLL_LIMIT) begin
            read_word(REG_STATUS, word);
            hit = word[23];                // wdog_timeout in status byte 2
            n++;
        end
        if (!hit) begin
            errors++;
            $display("timeout: watchdog never tripped");
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(negedge sysclk);                 // let assertion actions settle
        errs = errors - errors_at_start;
        test_num++;
        if (errs == 0)
            $display("test %0d %s: ok", test_num, name);
        else
            $display("test %0d %s: %0d errors", test_num, name, errs);
        errors_at_start = errors;
        @(posedge sysclk);
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    initial begin : stimulus
        axis_mask_t mask, val, h, p, n;
        logic       vf;
        reg_word_t  phy_c, phy_d, per;
        lfsr = LFSR_SEED;
        errors = 0;
        checks = 0;
        test_num = 0;
        errors_at_start = 0;
        rd_check = 1'b0;
        out_check = 1'b0;
        rd_exp = '0;
        rd_mask = '0;
        exp_amp = '0;
        exp_dout = '0;
        exp_pwr = 1'b0;
        exp_relay = 1'b0;
        reset = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        board_id = 4'hA;
        fault = 4'(take_bits(4));
        relay = 1'(take_bits(1));
        temp_sense = 16'(take_bits(16));
        prom_status = take_bits(32);
        prom_result = take_bits(32);
        neg_limit = '0;
        pos_limit = '0;
        home = '0;
        mv_good = 1'b0;
        v_fault = 1'b0;
        safety_amp_disable = '0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b1;
        @(posedge sysclk);

        check_outputs(4'hF, 1'b0, 1'b0, 4'h0);
        read_check(REG_VERSION, '1, BOARD_VERSION);
        read_check(REG_FW_VERSION, '1, FW_VERSION);
        // id byte, relay sense and faults, nothing enabled
        read_check(REG_STATUS, '1,
                   {NUM_AXES, board_id, 6'd0, ~relay, 1'b0, 4'd0, fault, 8'd0});
        read_check(REG_TEMPSNS, '1, {16'd0, temp_sense});
        read_check(REG_PROMSTAT, '1, prom_status);
        read_check(REG_PROMRES, '1, prom_result);
        read_check(4'd12, '1, '0);         // unmapped
        finish_test("reset state and constants");

        write_reg(8'h00, 32'h000F_0000);   // power + relay on
        check_outputs(4'hF, 1'b1, 1'b1, 4'h0);
        write_reg(8'h00, 32'h0000_0505);   // enable axes 1,3
        check_outputs(4'hF, 1'b1, 1'b1, 4'h0);  // mv_good low
        mv_good <= 1'b1;
        wait_amp(4'hA);
        check_outputs(4'hA, 1'b1, 1'b1, 4'h0);
        // mv_good, power, relay sense, relay and axes 1,3 enabled
        read_check(REG_STATUS, 32'h000F_000F, {12'd0, 2'b11, ~relay, 1'b1, 12'd0, 4'h5});
        write_reg(8'h00, 32'h0000_0202);   // axis 2 only
        check_outputs(4'h8, 1'b1, 1'b1, 4'h0);
        write_reg(8'h00, 32'h0008_0000);   // power off
        write_reg(8'h00, 32'h0000_0F0F);   // enable while unpowered
        check_outputs(4'hF, 1'b0, 1'b1, 4'h0);
        finish_test("power relay and enables");

        dout_model = '0;
        repeat (4) begin
            mask = 4'(take_bits(4));
            val  = 4'(take_bits(4));
            write_reg({4'd0, REG_DIGIOUT}, {20'd0, mask, 4'd0, val});
            dout_model = (mask & val) | (~mask & dout_model);
            check_outputs(4'hF, 1'b0, 1'b1, dout_model);
        end
        h  = 4'(take_bits(4));
        p  = 4'(take_bits(4));
        n  = 4'(take_bits(4));
        vf = 1'(take_bits(1));
        home <= h;
        pos_limit <= p;
        neg_limit <= n;
        v_fault <= vf;
        read_check(REG_DIGIN, '1, {15'd0, vf, dout_model, n, p, h});
        finish_test("digital outputs and inputs");

        phy_c = take_bits(32);
        phy_d = take_bits(32);
        per   = take_bits(32);
        write_reg(8'h01, phy_c);
        write_reg(8'h02, phy_d);
        write_reg(8'h03, per);
        read_check(REG_PHYCTRL, '1, {16'd0, phy_c[15:0]});
        read_check(REG_PHYDATA, '1, {16'd0, phy_d[15:0]});
        read_check(REG_TIMEOUT, '1, {16'd0, per[15:0]});
        write_reg(8'h51, ~phy_c);          // other channels
        write_reg(8'h62, ~phy_d);
        write_reg(8'h73, ~per);
        write_reg(8'h50, 32'h000C_0000);
        read_check(REG_PHYCTRL, '1, {16'd0, phy_c[15:0]});
        read_check(REG_PHYDATA, '1, {16'd0, phy_d[15:0]});
        read_check(REG_TIMEOUT, '1, {16'd0, per[15:0]});
        check_outputs(4'hF, 1'b0, 1'b1, dout_model);
        finish_test("scratch and channel decode");

        write_reg(8'h03, 32'h0000_0004);   // 4 tick period
        write_reg(8'h00, 32'h000C_0000);
        write_reg(8'h00, 32'h0000_0F0F);
        check_outputs(4'h0, 1'b1, 1'b1, dout_model);
        wait_wdog_trip();
        check_outputs(4'hF, 1'b1, 1'b1, dout_model);
        read_check(REG_WDOG, '1, 32'h0000_000F);
        write_reg(8'h03, 32'h0000_0000);   // kick and turn the watchdog off
        read_check(REG_STATUS, 32'h0080_000F, 32'h0);
        check_outputs(4'hF, 1'b1, 1'b1, dout_model);
        repeat (10) read_check(REG_STATUS, 32'h0080_0000, 32'h0);
        write_reg(8'h00, 32'h0000_0F0F);   // re-enable
        check_outputs(4'h0, 1'b1, 1'b1, dout_model);
        finish_test("watchdog");

        safety_amp_disable <= 4'h4;        // axis 3 tripped
        read_check(REG_SAFETY, '1, 32'h0000_0004);
        safety_amp_disable <= 4'h0;
        read_check(REG_SAFETY, '1, 32'h0);
        read_check(REG_REGDISABLE, '1, 32'h0000_0004);
        check_outputs(4'h4, 1'b1, 1'b1, dout_model);
        finish_test("external safety disable");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
